// ==== project.f ====
logic/core_pkg.sv
logic/decoder.sv
logic/register_file.sv
logic/alu.sv
logic/branch_logic.sv
logic/mem.sv
logic/core_top.sv
bench/clock_gen.sv
bench/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - logic/core_pkg.sv
  - logic/decoder.sv
  - logic/register_file.sv
  - logic/alu.sv
  - logic/branch_logic.sv
  - logic/mem.sv
  - logic/core_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/core_tb.sv

// ==== bench/core_tb.sv ====
// random 200-instruction program checked against an ISA model; data window fixed at 0x100
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam int imem_aw = 10;
  localparam int dmem_aw = 10;
  localparam int prog_len = 200;
  localparam int fault_idx = prog_len - 2;
  localparam int timeout_cycles = prog_len + 2 * prog_len + 50;
  localparam int k_op = 0;
  localparam int k_imm = 1;
  localparam int k_lui = 2;
  localparam int k_auipc = 3;
  localparam int k_br = 4;
  localparam int k_jal = 5;
  localparam int k_jalr = 6;
  localparam int k_load = 7;
  localparam int k_store = 8;

  logic               clk;
  logic               rst;
  logic               halt;
  logic               imem_we;
  logic [imem_aw-1:0] imem_addr;
  word_t              imem_wdata;
  logic               retire_valid;
  word_t              retire_pc;
  reg_idx_t           retire_rd;
  word_t              retire_data;
  logic               fault;

  // program as fields and as encoded words
  int         kind [prog_len];
  int         f_rd [prog_len];
  int         f_rs1 [prog_len];
  int         f_rs2 [prog_len];
  logic [2:0] f_f3 [prog_len];
  logic       f_alt [prog_len];
  word_t      f_imm [prog_len];
  word_t      prog [prog_len];

  word_t      model_regs [32];
  logic [7:0] model_mem [2 ** dmem_aw];
  word_t      exp_pc [$];
  int         exp_rd [$];
  word_t      exp_data [$];

  int   errors = 0;
  int   records = 0;
  int   cycles = 0;
  int   expected_total;
  logic prev_halt = 1'b1;

  clock_gen clock_gen_i (
    .clk(clk),
    .rst(rst)
  );

  core_top #(
    .imem_addr_width(imem_aw),
    .dmem_addr_width(dmem_aw)
  ) core_top_i (
    .clk(clk),
    .rst(rst),
    .halt(halt),
    .imem_we(imem_we),
    .imem_addr(imem_addr),
    .imem_wdata(imem_wdata),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .fault(fault)
  );

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // ISA semantics of the integer operations
  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t encode(int i);
    word_t m;
    logic [6:0] opc;
    m = f_imm[i];
    case (kind[i])
      k_op: opc = opc_op;
      k_imm: opc = opc_op_imm;
      k_lui: opc = opc_lui;
      k_auipc: opc = opc_auipc;
      k_br: opc = opc_branch;
      k_jal: opc = opc_jal;
      k_jalr: opc = opc_jalr;
      k_load: opc = opc_load;
      default: opc = opc_store;
    endcase
    case (kind[i])
      k_op: return {1'b0, f_alt[i], 5'b0, 5'(f_rs2[i]), 5'(f_rs1[i]), f_f3[i], 5'(f_rd[i]), opc};
      k_lui, k_auipc: return {m[31:12], 5'(f_rd[i]), opc};
      k_br: return {m[12], m[10:5], 5'(f_rs2[i]), 5'(f_rs1[i]), f_f3[i], m[4:1], m[11], opc};
      k_jal: return {m[20], m[10:1], m[11], m[19:12], 5'(f_rd[i]), opc};
      k_store: return {m[11:5], 5'(f_rs2[i]), 5'(f_rs1[i]), f_f3[i], m[4:0], opc};
      default: return {m[11:0], 5'(f_rs1[i]), f_f3[i], 5'(f_rd[i]), opc};
    endcase
  endfunction

  // destination, now and then x0
  function automatic int pick_rd();
    if ($urandom_range(15, 0) == 0) begin
      return 0;
    end
    return $urandom_range(31, 2);
  endfunction

  task automatic set_instr(input int i, input int k, input int rd, input int rs1, input int rs2,
                           input logic [2:0] f3, input logic alt, input word_t imm);
    kind[i] = k;
    f_rd[i] = rd;
    f_rs1[i] = rs1;
    f_rs2[i] = rs2;
    f_f3[i] = f3;
    f_alt[i] = alt;
    f_imm[i] = imm;
  endtask

  task automatic generate_program();
    int prev_rd;
    int k;
    int rs1;
    int off;
    logic [2:0] f3;
    logic alt;
    // seed registers, x1 is the data window base
    set_instr(0, k_imm, 1, 0, 0, 3'd0, 1'b0, 32'h100);
    for (int r = 2; r < 32; r++) begin
      set_instr(r - 1, k_imm, r, 0, 0, 3'd0, 1'b0, word_t'($signed(12'($urandom))));
    end
    // fill the whole window so loads never see unwritten bytes
    for (int w = 0; w < 16; w++) begin
      set_instr(31 + w, k_store, 0, 1, w + 2, 3'd2, 1'b0, 32'(4 * w));
    end
    prev_rd = 31;
    for (int i = 47; i < fault_idx; i++) begin
      rs1 = ($urandom_range(2, 0) == 0) ? prev_rd : $urandom_range(31, 0);
      k = $urandom_range(fault_idx - i < 4 ? fault_idx - i : 4, 1);
      case ($urandom_range(8, 0))
        0: begin
          f3 = 3'($urandom);
          alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom) : 1'b0;
          set_instr(i, k_op, pick_rd(), rs1, $urandom_range(31, 0), f3, alt, 0);
        end
        1: begin
          f3 = 3'($urandom);
          alt = (f3 == 3'd5) ? 1'($urandom) : 1'b0;
          if (f3 == 3'd1 || f3 == 3'd5) begin
            set_instr(i, k_imm, pick_rd(), rs1, 0, f3, alt, {21'b0, alt, 5'b0, 5'($urandom)});
          end else begin
            set_instr(i, k_imm, pick_rd(), rs1, 0, f3, 1'b0, word_t'($signed(12'($urandom))));
          end
        end
        2: set_instr(i, k_lui, pick_rd(), 0, 0, 3'd0, 1'b0, {20'($urandom), 12'b0});
        3: set_instr(i, k_auipc, pick_rd(), 0, 0, 3'd0, 1'b0, {20'($urandom), 12'b0});
        4: begin
          f3 = 3'($urandom);
          if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = 3'd0;
          end
          set_instr(i, k_br, 0, rs1, $urandom_range(31, 0), f3, 1'b0, 32'(4 * k));
        end
        5: set_instr(i, k_jal, pick_rd(), 0, 0, 3'd0, 1'b0, 32'(4 * k));
        6: set_instr(i, k_jalr, pick_rd(), 0, 0, 3'd0, 1'b0, 32'(4 * (i + k)));
        7: begin
          f3 = 3'($urandom_range(4, 0));
          f3 = (f3 > 3'd2) ? f3 + 3'd1 : f3;
          off = $urandom_range(63, 0) & ~((1 << f3[1:0]) - 1);
          set_instr(i, k_load, pick_rd(), 1, 0, f3, 1'b0, 32'(off));
        end
        default: begin
          f3 = 3'($urandom_range(2, 0));
          off = $urandom_range(63, 0) & ~((1 << f3[1:0]) - 1);
          set_instr(i, k_store, 0, 1, $urandom_range(31, 0), f3, 1'b0, 32'(off));
        end
      endcase
      if (kind[i] != k_br && kind[i] != k_store) begin
        prev_rd = f_rd[i];
      end
    end
    // misaligned word load, then a self loop that is never reached
    set_instr(fault_idx, k_load, 5, 1, 0, 3'd2, 1'b0, 32'd2);
    set_instr(fault_idx + 1, k_jal, 0, 0, 0, 3'd0, 1'b0, 32'd0);
    for (int i = 0; i < prog_len; i++) begin
      prog[i] = encode(i);
    end
  endtask

  task automatic run_model();
    word_t pc;
    word_t a;
    word_t b;
    word_t val;
    word_t next;
    word_t addr;
    int i;
    int rd;
    logic taken;
    pc = 0;
    model_regs = '{default: '0};
    i = 0;
    while (i != fault_idx) begin
      a = model_regs[f_rs1[i]];
      b = model_regs[f_rs2[i]];
      rd = f_rd[i];
      val = 0;
      next = pc + 4;
      addr = (a + f_imm[i]) & ((1 << dmem_aw) - 1);
      case (kind[i])
        k_op: val = alu_model(f_f3[i], f_alt[i], a, b);
        k_imm: val = alu_model(f_f3[i], f_alt[i], a, f_imm[i]);
        k_lui: val = f_imm[i];
        k_auipc: val = pc + f_imm[i];
        k_jal, k_jalr: begin
          val = pc + 4;
          next = (kind[i] == k_jal) ? pc + f_imm[i] : (a + f_imm[i]) & ~32'd1;
        end
        k_br: begin
          case (f_f3[i])
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            default: taken = a >= b;
          endcase
          next = taken ? pc + f_imm[i] : pc + 4;
        end
        k_load: begin
          val = {model_mem[addr + 3], model_mem[addr + 2], model_mem[addr + 1], model_mem[addr]};
          case (f_f3[i])
            3'd0: val = word_t'($signed(val[7:0]));
            3'd1: val = word_t'($signed(val[15:0]));
            3'd4: val = {24'b0, val[7:0]};
            3'd5: val = {16'b0, val[15:0]};
            default: val = val;
          endcase
        end
        default: begin
          for (int n = 0; n < (1 << f_f3[i][1:0]); n++) begin
            model_mem[addr + n] = b[8*n +: 8];
          end
        end
      endcase
      if (rd == 0) begin
        val = 0;
      end
      model_regs[rd] = val;
      model_regs[0] = 0;
      exp_pc.push_back(pc);
      exp_rd.push_back(rd);
      exp_data.push_back(val);
      pc = next;
      i = pc / 4;
    end
  endtask

  // compare each retire record with the model's next one
  always @(negedge clk) begin
    if (prev_halt) begin
      check("retire_valid", 32'(retire_valid), 32'd0);
    end
    if (retire_valid) begin
      if (exp_pc.size() == 0) begin
        $display("an instruction retired after the expected stream had ended");
        errors++;
      end else begin
        check("retire_pc", retire_pc, exp_pc.pop_front());
        check("retire_rd", 32'(retire_rd), 32'(exp_rd.pop_front()));
        check("retire_data", retire_data, exp_data.pop_front());
        records++;
      end
    end
    prev_halt = halt;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("timeout after %0d cycles without reaching the fault", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    halt = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_wdata = '0;
    void'($urandom(44345));
    generate_program();
    run_model();
    expected_total = exp_pc.size();
    wait (rst == 1'b0);
    for (int i = 0; i < prog_len; i++) begin
      step();
      imem_we = 1'b1;
      imem_addr = imem_aw'(4 * i);
      imem_wdata = prog[i];
    end
    step();
    imem_we = 1'b0;
    halt = 1'b0;
    // pause the core somewhere inside the random section
    repeat ($urandom_range(80, 50)) step();
    halt = 1'b1;
    repeat ($urandom_range(8, 1)) step();
    halt = 1'b0;
    while (!fault) begin
      step();
    end
    repeat (4) step();
    check("fault", 32'(fault), 32'd1);
    check("retired record count", 32'(records), 32'(expected_total));
    $display("%0d records checked, %0d errors", records, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== bench/clock_gen.sv ====
// 20 ns testbench clock; reset is high for the first two rising edges
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// ==== logic/core_top.sv ====
// single-cycle RV32I core without CSR, FENCE or traps; addresses wrap at the memory sizes
`timescale 1ns/1ps

module core_top #(
  parameter int imem_addr_width = 10,
  parameter int dmem_addr_width = 10
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       halt,
  input  logic                       imem_we,
  input  logic [imem_addr_width-1:0] imem_addr,
  input  core_pkg::word_t            imem_wdata,
  output logic                       retire_valid,
  output core_pkg::word_t            retire_pc,
  output core_pkg::reg_idx_t         retire_rd,
  output core_pkg::word_t            retire_data,
  output logic                       fault
);
  import core_pkg::*;

  word_t      pc;
  word_t      pc_plus_4;
  word_t      pc_target;
  word_t      pc_next;
  logic       exec;
  logic       fault_event;
  logic       commit;
  logic       rf_we;

  word_t      instr;
  reg_idx_t   dec_rs1;
  reg_idx_t   dec_rs2;
  reg_idx_t   dec_rd;
  word_t      dec_imm;
  alu_op_t    dec_alu_op;
  logic       dec_sub_arith;
  alu_a_sel_t dec_alu_a_sel;
  alu_b_sel_t dec_alu_b_sel;
  logic       dec_branch_instr;
  logic       dec_branch_always;
  branch_op_t dec_branch_op;
  logic       dec_dmem_we;
  logic       dec_dmem_sign_extend;
  mem_width_t dec_dmem_width;
  logic       dec_mem_access;
  wb_sel_t    dec_wb_sel;
  logic       dec_wb_we;

  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_res;
  logic       take;
  word_t      dmem_data;
  logic       dmem_align_err;
  word_t      wb_value;

  assign pc_plus_4 = pc + 32'd4;
  // jalr needs bit 0 cleared, the other targets are already even
  assign pc_target = {alu_res[31:1], 1'b0};
  assign pc_next   = take ? pc_target : pc_plus_4;

  // nothing executes while halted, faulted or in reset
  assign exec = !halt && !fault && !rst;
  // misaligned data access, or a jump target off a word boundary
  assign fault_event = exec && ((dec_mem_access && dmem_align_err) || (take && pc_target[1]));
  assign commit = exec && !fault_event;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      retire_valid <= 1'b0;
      rf_we        <= 1'b0;
      fault        <= 1'b0;
    end else begin
      if (commit) begin
        pc <= pc_next;
      end
      retire_valid <= commit;
      rf_we        <= commit && dec_wb_we;
      if (fault_event) begin
        fault <= 1'b1;
      end
    end
  end

  // write-back payload, qualified by retire_valid
  always_ff @(posedge clk) begin
    retire_pc   <= pc;
    retire_rd   <= dec_rd;
    retire_data <= (dec_rd != '0) ? wb_value : '0;
  end

  mem #(
    .addr_width(imem_addr_width)
  ) imem (
    .clk(clk),
    .write_enable(imem_we && halt),
    .width(mem_word),
    .sign_extend(1'b0),
    .address(halt ? imem_addr : pc[imem_addr_width-1:0]),
    .data_in(imem_wdata),
    .data_out(instr),
    .alignment_error()
  );

  decoder decoder_i (
    .instr(instr),
    .rs1(dec_rs1),
    .rs2(dec_rs2),
    .rd(dec_rd),
    .imm(dec_imm),
    .alu_op(dec_alu_op),
    .sub_arith(dec_sub_arith),
    .alu_a_sel(dec_alu_a_sel),
    .alu_b_sel(dec_alu_b_sel),
    .branch_instr(dec_branch_instr),
    .branch_always(dec_branch_always),
    .branch_op(dec_branch_op),
    .dmem_write_enable(dec_dmem_we),
    .dmem_sign_extend(dec_dmem_sign_extend),
    .dmem_width(dec_dmem_width),
    .mem_access(dec_mem_access),
    .wb_sel(dec_wb_sel),
    .wb_write_enable(dec_wb_we)
  );

  // written from the registered write-back, one cycle after execute
  register_file rf (
    .clk(clk),
    .rst(rst),
    .write_enable(rf_we),
    .write_addr(retire_rd),
    .write_data(retire_data),
    .read_addr1(dec_rs1),
    .read_addr2(dec_rs2),
    .read_data1(rs1_data),
    .read_data2(rs2_data)
  );

  always_comb begin
    case (dec_alu_a_sel)
      a_rs1:   alu_a = rs1_data;
      a_pc:    alu_a = pc;
      default: alu_a = '0;
    endcase
  end

  assign alu_b = (dec_alu_b_sel == b_imm) ? dec_imm : rs2_data;

  alu alu_i (
    .a(alu_a),
    .b(alu_b),
    .op(dec_alu_op),
    .sub_arith(dec_sub_arith),
    .res(alu_res)
  );

  branch_logic branch_i (
    .a(rs1_data),
    .b(rs2_data),
    .branch_instr(dec_branch_instr),
    .branch_always(dec_branch_always),
    .op(dec_branch_op),
    .take(take)
  );

  mem #(
    .addr_width(dmem_addr_width)
  ) dmem (
    .clk(clk),
    .write_enable(dec_dmem_we && exec),
    .width(dec_dmem_width),
    .sign_extend(dec_dmem_sign_extend),
    .address(alu_res[dmem_addr_width-1:0]),
    .data_in(rs2_data),
    .data_out(dmem_data),
    .alignment_error(dmem_align_err)
  );

  always_comb begin
    case (dec_wb_sel)
      wb_dmem:      wb_value = dmem_data;
      wb_pc_plus_4: wb_value = pc_plus_4;
      default:      wb_value = alu_res;
    endcase
  end

  // fetch address stays on a word boundary
  pc_aligned_a : assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00)
    else $error("PC left a word boundary");

endmodule

// ==== logic/mem.sv ====
// word-organized RAM of 2**addr_width bytes without reset; misaligned writes are dropped
`timescale 1ns/1ps

module mem #(
  parameter int addr_width = 10
) (
  input  logic                  clk,
  input  logic                  write_enable,
  input  core_pkg::mem_width_t  width,
  input  logic                  sign_extend,
  input  logic [addr_width-1:0] address,
  input  core_pkg::word_t       data_in,
  output core_pkg::word_t       data_out,
  output logic                  alignment_error
);
  import core_pkg::*;

  localparam int depth = 2 ** (addr_width - 2);

  word_t                 storage [depth];
  logic [addr_width-3:0] word_addr;
  logic [3:0]            lanes;
  word_t                 lane_data;
  word_t                 shifted;
  logic                  array_we;

  assign word_addr = address[addr_width-1:2];

  assign alignment_error = (width == mem_half && address[0]) ||
                           (width == mem_word && address[1:0] != 2'b00);

  assign array_we = write_enable && !alignment_error;

  // byte enables and replicated data for the addressed lanes
  always_comb begin
    case (width)
      mem_byte: begin
        lanes     = 4'b0001 << address[1:0];
        lane_data = {4{data_in[7:0]}};
      end
      mem_half: begin
        lanes     = 4'b0011 << {address[1], 1'b0};
        lane_data = {2{data_in[15:0]}};
      end
      default: begin
        lanes     = 4'b1111;
        lane_data = data_in;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (array_we) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) begin
          storage[word_addr][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  // move the addressed byte or half down to bit 0
  assign shifted = storage[word_addr] >> {address[1:0], 3'b000};

  always_comb begin
    case (width)
      mem_byte: data_out = {{24{sign_extend & shifted[7]}}, shifted[7:0]};
      mem_half: data_out = {{16{sign_extend & shifted[15]}}, shifted[15:0]};
      default:  data_out = shifted;
    endcase
  end

  // a flagged access leaves the addressed word untouched at the edge
  no_misaligned_write_a : assert property (@(posedge clk)
    alignment_error |=> storage[$past(word_addr)] === $past(storage[word_addr]))
    else $error("misaligned access changed the memory");

endmodule

// ==== logic/branch_logic.sv ====
// branch condition unit; a jump is always taken and reserved branch codes never are
`timescale 1ns/1ps

module branch_logic (
  input  core_pkg::word_t      a,
  input  core_pkg::word_t      b,
  input  logic                 branch_instr,
  input  logic                 branch_always,
  input  core_pkg::branch_op_t op,
  output logic                 take
);
  import core_pkg::*;

  logic cond;

  always_comb begin
    case (op)
      br_beq:  cond = a == b;
      br_bne:  cond = a != b;
      br_blt:  cond = $signed(a) < $signed(b);
      br_bge:  cond = $signed(a) >= $signed(b);
      br_bltu: cond = a < b;
      br_bgeu: cond = a >= b;
      default: cond = 1'b0;
    endcase
  end

  // jal and jalr ignore the compare
  assign take = branch_always || (branch_instr && cond);

endmodule

// ==== logic/alu.sv ====
// RV32I integer ALU; shift amounts use only the low five bits of b
`timescale 1ns/1ps

module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  core_pkg::alu_op_t op,
  input  logic              sub_arith,
  output core_pkg::word_t   res
);
  import core_pkg::*;

  logic [4:0] shamt;
  word_t      sum;
  word_t      shift_right;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = b[4:0];

  // add or sub
  assign sum = sub_arith ? a - b : a + b;

  // srl or sra
  assign shift_right = sub_arith ? word_t'($signed(a) >>> shamt) : a >> shamt;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add: begin
        res = sum;
      end
      alu_sll: begin
        res = a << shamt;
      end
      alu_slt: begin
        res = {31'b0, lt_signed};
      end
      alu_sltu: begin
        res = {31'b0, lt_unsigned};
      end
      alu_xor: begin
        res = a ^ b;
      end
      alu_srl: begin
        res = shift_right;
      end
      alu_or: begin
        res = a | b;
      end
      alu_and: begin
        res = a & b;
      end
      default: begin
        res = sum;
      end
    endcase
  end

endmodule

// ==== logic/register_file.sv ====
// 32 x 32 register file with x0 tied to zero; a same-cycle write is forwarded to both read ports
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               rst,
  input  logic               write_enable,
  input  core_pkg::reg_idx_t write_addr,
  input  core_pkg::word_t    write_data,
  input  core_pkg::reg_idx_t read_addr1,
  input  core_pkg::reg_idx_t read_addr2,
  output core_pkg::word_t    read_data1,
  output core_pkg::word_t    read_data2
);
  import core_pkg::*;

  word_t regs [32];
  logic  bypass1;
  logic  bypass2;

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (write_enable && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // forward the pending write, never for x0
  assign bypass1 = write_enable && write_addr != '0 && write_addr == read_addr1;
  assign bypass2 = write_enable && write_addr != '0 && write_addr == read_addr2;

  assign read_data1 = bypass1 ? write_data : regs[read_addr1];
  assign read_data2 = bypass2 ? write_data : regs[read_addr2];

  // x0 must stay zero over the whole run
  x0_zero_a : assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

// ==== logic/decoder.sv ====
// RV32I decoder for the kept subset; any other encoding becomes a no-op that writes nothing
`timescale 1ns/1ps

module decoder (
  input  core_pkg::word_t      instr,
  output core_pkg::reg_idx_t   rs1,
  output core_pkg::reg_idx_t   rs2,
  output core_pkg::reg_idx_t   rd,
  output core_pkg::word_t      imm,
  output core_pkg::alu_op_t    alu_op,
  output logic                 sub_arith,
  output core_pkg::alu_a_sel_t alu_a_sel,
  output core_pkg::alu_b_sel_t alu_b_sel,
  output logic                 branch_instr,
  output logic                 branch_always,
  output core_pkg::branch_op_t branch_op,
  output logic                 dmem_write_enable,
  output logic                 dmem_sign_extend,
  output core_pkg::mem_width_t dmem_width,
  output logic                 mem_access,
  output core_pkg::wb_sel_t    wb_sel,
  output logic                 wb_write_enable
);
  import core_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // no write means no destination
  assign rd = wb_write_enable ? instr[11:7] : '0;

  always_comb begin
    imm               = '0;
    alu_op            = alu_add;
    sub_arith         = 1'b0;
    alu_a_sel         = a_rs1;
    alu_b_sel         = b_rs2;
    branch_instr      = 1'b0;
    branch_always     = 1'b0;
    branch_op         = br_beq;
    dmem_write_enable = 1'b0;
    dmem_sign_extend  = 1'b0;
    dmem_width        = mem_word;
    mem_access        = 1'b0;
    wb_sel            = wb_alu;
    wb_write_enable   = 1'b0;

    case (opcode)
      opc_op: begin
        alu_op          = alu_op_t'(funct3);
        sub_arith       = funct7_b5;
        wb_write_enable = 1'b1;
      end
      opc_op_imm: begin
        imm             = imm_i;
        alu_b_sel       = b_imm;
        alu_op          = alu_op_t'(funct3);
        // only srai uses funct7, addi has no subtract form
        sub_arith       = (funct3 == 3'b101) && funct7_b5;
        wb_write_enable = 1'b1;
      end
      opc_lui: begin
        imm             = imm_u;
        alu_a_sel       = a_zero;
        alu_b_sel       = b_imm;
        wb_write_enable = 1'b1;
      end
      opc_auipc: begin
        imm             = imm_u;
        alu_a_sel       = a_pc;
        alu_b_sel       = b_imm;
        wb_write_enable = 1'b1;
      end
      opc_jal: begin
        imm             = imm_j;
        alu_a_sel       = a_pc;
        alu_b_sel       = b_imm;
        branch_always   = 1'b1;
        wb_sel          = wb_pc_plus_4;
        wb_write_enable = 1'b1;
      end
      opc_jalr: begin
        imm             = imm_i;
        alu_b_sel       = b_imm;
        branch_always   = 1'b1;
        wb_sel          = wb_pc_plus_4;
        wb_write_enable = 1'b1;
      end
      opc_branch: begin
        imm       = imm_b;
        alu_a_sel = a_pc;
        alu_b_sel = b_imm;
        branch_op = branch_op_t'(funct3);
        // funct3 010 and 011 are reserved
        branch_instr = (funct3[2:1] != 2'b01);
      end
      opc_load: begin
        // lb lh lw lbu lhu only
        if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) begin
          imm              = imm_i;
          alu_b_sel        = b_imm;
          mem_access       = 1'b1;
          dmem_width       = mem_width_t'(funct3[1:0]);
          dmem_sign_extend = !funct3[2];
          wb_sel           = wb_dmem;
          wb_write_enable  = 1'b1;
        end
      end
      opc_store: begin
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          imm               = imm_s;
          alu_b_sel         = b_imm;
          mem_access        = 1'b1;
          dmem_width        = mem_width_t'(funct3[1:0]);
          dmem_write_enable = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== logic/core_pkg.sv ====
// shared RV32I types; enum encodings follow the funct3 fields so the decoder can cast them directly
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes kept by the core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_t;

  // funct3 order, sub and sra come from a separate sub_arith bit
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_t;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_op_t;

  // low two bits of the load/store funct3
  typedef enum logic [1:0] {
    mem_byte = 2'b00,
    mem_half = 2'b01,
    mem_word = 2'b10
  } mem_width_t;

  typedef enum logic [1:0] {
    a_rs1  = 2'b00,
    a_pc   = 2'b01,
    a_zero = 2'b10
  } alu_a_sel_t;

  typedef enum logic {
    b_rs2 = 1'b0,
    b_imm = 1'b1
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    wb_alu       = 2'b00,
    wb_dmem      = 2'b01,
    wb_pc_plus_4 = 2'b10
  } wb_sel_t;

endpackage
